// File: design/cache_pkg.sv
// cache package: word types, transfer and controller enums, geometry helpers
package cache_pkg;

    localparam int WORD_SIZE = 32;

    typedef logic [WORD_SIZE-1:0] word_t;     // data or address word
    typedef logic [3:0]           byte_en_t;  // bit n selects byte n

    typedef enum logic {
        FILL,
        EVICT
    } xfer_op_t;

    typedef enum logic [2:0] {
        CLEAR,
        LOOKUP,
        EVICT_WAIT,
        FILL_WAIT,
        FLUSH_SCAN,
        FLUSH_WAIT
    } ctrl_state_t;

    // index width, at least one bit so a single-set cache still has a port
    function automatic int set_bits(int cache_size, int block_size);
        int sets;
        sets = cache_size / ((WORD_SIZE / 8) * block_size);
        return (sets > 1) ? $clog2(sets) : 1;
    endfunction

    // word offset width inside a block, at least one bit
    function automatic int block_bits(int block_size);
        return (block_size > 1) ? $clog2(block_size) : 1;
    endfunction

    // whatever is left above byte, word and set fields
    function automatic int tag_bits(int cache_size, int block_size);
        int sets;
        sets = cache_size / ((WORD_SIZE / 8) * block_size);
        return WORD_SIZE - 2 - $clog2(block_size) - $clog2(sets);
    endfunction

endpackage

// File: design/store_port_if.sv
// line array access port: index, combinational frame read and masked frame write
`timescale 1ns/1ps

interface store_port_if import cache_pkg::*; #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 4
) ();

    localparam int SB      = set_bits(CACHE_SIZE, BLOCK_SIZE);
    localparam int TB      = tag_bits(CACHE_SIZE, BLOCK_SIZE);
    localparam int FRAME_W = WORD_SIZE * BLOCK_SIZE + TB + 2;  // {valid, dirty, tag, data}

    logic [SB-1:0]         index;
    logic [FRAME_W-1:0]    rd_frame;
    logic [2:0]            wen;        // {valid, dirty, tag} field enables
    logic [FRAME_W-1:0]    wr_frame;
    logic [BLOCK_SIZE-1:0] word_mask;  // data words to write
    byte_en_t              byte_mask;  // bytes inside each selected word

    modport master (output index, wen, wr_frame, word_mask, byte_mask, input rd_frame);
    modport array  (input index, wen, wr_frame, word_mask, byte_mask, output rd_frame);

endinterface

// File: design/xfer_if.sv
// block transfer command link between controller and transfer engine
`timescale 1ns/1ps

interface xfer_if import cache_pkg::*; #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 4
) ();

    localparam int SB = set_bits(CACHE_SIZE, BLOCK_SIZE);
    localparam int TB = tag_bits(CACHE_SIZE, BLOCK_SIZE);

    logic          req;  // four-phase with ack
    logic          ack;
    xfer_op_t      op;
    logic [SB-1:0] set;
    logic [TB-1:0] tag;  // fill tag, evict uses the stored one

    modport initiator (output req, op, set, tag, input ack);
    modport target    (input req, op, set, tag, output ack);

endinterface

// File: design/cache_store.sv
// cache line array: valid, dirty, tag and data per set, two ports, field and byte masked writes
`timescale 1ns/1ps

module cache_store import cache_pkg::*; #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 4
) (
    input logic         CLK,
    input logic         nRST,
    store_port_if.array port_a,
    store_port_if.array port_b
);

    localparam int N_SETS  = CACHE_SIZE / ((WORD_SIZE / 8) * BLOCK_SIZE);
    localparam int TB      = tag_bits(CACHE_SIZE, BLOCK_SIZE);
    localparam int DATA_W  = WORD_SIZE * BLOCK_SIZE;
    localparam int FRAME_W = DATA_W + TB + 2;
    localparam int V_BIT   = FRAME_W - 1;
    localparam int D_BIT   = FRAME_W - 2;

    logic [FRAME_W-1:0] frames [N_SETS];

    // apply one port's write on top of the current frame
    function automatic logic [FRAME_W-1:0] merge(
        input logic [FRAME_W-1:0]    cur,
        input logic [FRAME_W-1:0]    wr,
        input logic [2:0]            ctl,
        input logic [BLOCK_SIZE-1:0] wmask,
        input byte_en_t              bmask
    );
        logic [FRAME_W-1:0] res;
        res = cur;
        if (ctl[2])
            res[V_BIT] = wr[V_BIT];
        if (ctl[1])
            res[D_BIT] = wr[D_BIT];
        if (ctl[0])
            res[DATA_W +: TB] = wr[DATA_W +: TB];
        for (int w = 0; w < BLOCK_SIZE; w++) begin
            for (int b = 0; b < WORD_SIZE / 8; b++) begin
                if (wmask[w] && bmask[b])
                    res[w*WORD_SIZE + b*8 +: 8] = wr[w*WORD_SIZE + b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign port_a.rd_frame = frames[port_a.index];  // combinational read
    assign port_b.rd_frame = frames[port_b.index];

    // the controller's CLEAR walk invalidates every set after reset
    always_ff @(posedge CLK) begin
        if (nRST) begin  // hold off writes while in reset
            if (|port_a.wen || |port_a.word_mask)
                frames[port_a.index] <= merge(frames[port_a.index], port_a.wr_frame,
                                              port_a.wen, port_a.word_mask, port_a.byte_mask);
            // later assignment, so port b wins on a collision
            if (|port_b.wen || |port_b.word_mask)
                frames[port_b.index] <= merge(frames[port_b.index], port_b.wr_frame,
                                              port_b.wen, port_b.word_mask, port_b.byte_mask);
        end
    end

endmodule

// File: design/line_transfer.sv
// line transfer engine: fills or evicts one block over the memory port, a word per ack
`timescale 1ns/1ps

module line_transfer import cache_pkg::*; #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 4
) (
    input  logic          CLK,
    input  logic          nRST,
    xfer_if.target        cmd,
    store_port_if.master  store,
    output logic          mem_ren,
    output logic          mem_wen,
    output word_t         mem_addr,
    output word_t         mem_wdata,
    input  word_t         mem_rdata,
    input  logic          mem_busy
);

    localparam int BB      = block_bits(BLOCK_SIZE);
    localparam int TB      = tag_bits(CACHE_SIZE, BLOCK_SIZE);
    localparam int DATA_W  = WORD_SIZE * BLOCK_SIZE;
    localparam int FRAME_W = DATA_W + TB + 2;
    localparam int SET_LSB = 2 + $clog2(BLOCK_SIZE);
    localparam int TAG_LSB = WORD_SIZE - TB;

    logic          active;    // words still moving
    logic          ack_q;
    logic [BB-1:0] word_cnt;
    logic          word_done; // memory took or gave a word this cycle
    logic          last_word;
    logic [TB-1:0] blk_tag;

    assign cmd.ack   = ack_q;
    assign word_done = active && !mem_busy;
    assign last_word = (word_cnt == BB'(BLOCK_SIZE - 1));

    // evict goes back to where the victim came from
    assign blk_tag = (cmd.op == EVICT) ? store.rd_frame[DATA_W +: TB] : cmd.tag;

    assign mem_ren   = active && (cmd.op == FILL);
    assign mem_wen   = active && (cmd.op == EVICT);
    assign mem_addr  = (word_t'(blk_tag) << TAG_LSB) | (word_t'(cmd.set) << SET_LSB)
                     | (word_t'(word_cnt) << 2);
    assign mem_wdata = store.rd_frame[word_cnt*WORD_SIZE +: WORD_SIZE];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            active   <= 1'b0;
            ack_q    <= 1'b0;
            word_cnt <= '0;
        end else begin
            if (cmd.req && !active && !ack_q) begin  // start cycle
                active   <= 1'b1;
                word_cnt <= '0;
            end else if (word_done) begin
                if (last_word) begin
                    active   <= 1'b0;
                    ack_q    <= 1'b1;
                    word_cnt <= '0;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end else if (ack_q && !cmd.req) begin
                ack_q <= 1'b0;  // handshake closed
            end
        end
    end

    // array side, port b
    always_comb begin
        store.index     = cmd.set;
        store.wen       = 3'b000;
        store.word_mask = '0;
        store.byte_mask = '1;
        store.wr_frame  = '0;
        store.wr_frame[0 +: DATA_W]  = {BLOCK_SIZE{mem_rdata}};
        store.wr_frame[DATA_W +: TB] = cmd.tag;
        store.wr_frame[FRAME_W-1]    = (cmd.op == FILL);  // valid after fill, cleared after evict

        if (word_done && cmd.op == FILL)
            store.word_mask[word_cnt] = 1'b1;
        if (word_done && last_word)
            store.wen = (cmd.op == FILL) ? 3'b111 : 3'b110;  // dirty always cleared
    end

endmodule

// File: design/cache_ctrl.sv
// cache controller FSM: clear, lookup, hit service, miss dispatch and flush walk
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 4
) (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         flush,
    output logic         flush_done,
    input  logic         proc_ren,
    input  logic         proc_wen,
    input  word_t        proc_addr,
    input  byte_en_t     proc_byte_en,
    input  word_t        proc_wdata,
    output word_t        proc_rdata,
    output logic         proc_busy,
    store_port_if.master store,
    xfer_if.initiator    xfer
);

    localparam int N_SETS  = CACHE_SIZE / ((WORD_SIZE / 8) * BLOCK_SIZE);
    localparam int SB      = set_bits(CACHE_SIZE, BLOCK_SIZE);
    localparam int BB      = block_bits(BLOCK_SIZE);
    localparam int TB      = tag_bits(CACHE_SIZE, BLOCK_SIZE);
    localparam int DATA_W  = WORD_SIZE * BLOCK_SIZE;
    localparam int FRAME_W = DATA_W + TB + 2;
    localparam int SET_LSB = 2 + $clog2(BLOCK_SIZE);
    localparam int TAG_LSB = WORD_SIZE - TB;

    ctrl_state_t   state, next_state;
    logic [SB-1:0] scan_cnt;     // set walker for clear and flush
    logic          scan_step;
    logic          last_set;
    logic          flush_pend;

    logic [TB-1:0] req_tag;
    logic [SB-1:0] req_set;
    logic [BB-1:0] req_word;
    logic          access, hit, line_valid, line_dirty;

    // address decode, masks cover single-word blocks and single-set caches
    assign req_tag  = proc_addr[TAG_LSB +: TB];
    assign req_set  = proc_addr[SET_LSB +: SB] & SB'(N_SETS - 1);
    assign req_word = proc_addr[2 +: BB] & BB'(BLOCK_SIZE - 1);

    assign access     = proc_ren || proc_wen;
    assign line_valid = store.rd_frame[FRAME_W-1];
    assign line_dirty = store.rd_frame[FRAME_W-2];
    assign hit        = line_valid && (store.rd_frame[DATA_W +: TB] == req_tag);
    assign last_set   = (scan_cnt == SB'(N_SETS - 1));
    assign proc_rdata = store.rd_frame[req_word*WORD_SIZE +: WORD_SIZE];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= CLEAR;
            scan_cnt   <= '0;
            flush_pend <= 1'b0;
        end else begin
            state <= next_state;
            if (scan_step)
                scan_cnt <= last_set ? '0 : scan_cnt + 1'b1;
            if (state == FLUSH_SCAN)
                flush_pend <= 1'b0;
            else if (flush)
                flush_pend <= 1'b1;
        end
    end

    always_comb begin
        next_state      = state;
        proc_busy       = 1'b1;
        flush_done      = 1'b0;
        scan_step       = 1'b0;
        store.index     = req_set;
        store.wen       = 3'b000;
        store.wr_frame  = '0;        // valid and dirty low unless set below
        store.word_mask = '0;
        store.byte_mask = proc_byte_en;
        xfer.req        = 1'b0;
        xfer.op         = FILL;
        xfer.set        = req_set;
        xfer.tag        = req_tag;

        unique case (state)
            CLEAR: begin
                store.index = scan_cnt;
                store.wen   = 3'b110;  // drop valid and dirty
                scan_step   = 1'b1;
                if (last_set)
                    next_state = LOOKUP;
            end
            LOOKUP: begin
                proc_busy = !(access && hit);
                if (proc_wen && hit) begin
                    store.wen                     = 3'b010;
                    store.wr_frame[FRAME_W-2]     = 1'b1;
                    store.wr_frame[0 +: DATA_W]   = {BLOCK_SIZE{proc_wdata}};
                    store.word_mask[req_word]     = 1'b1;
                end
                if (flush_pend && !(access && hit))
                    next_state = FLUSH_SCAN;
                else if (access && !hit)
                    next_state = (line_valid && line_dirty) ? EVICT_WAIT : FILL_WAIT;
            end
            EVICT_WAIT: begin
                xfer.req = !xfer.ack;
                xfer.op  = EVICT;
                if (xfer.ack)
                    next_state = FILL_WAIT;
            end
            FILL_WAIT: begin
                xfer.req = !xfer.ack;
                if (xfer.ack)
                    next_state = LOOKUP;  // retried as a hit
            end
            FLUSH_SCAN: begin
                store.index = scan_cnt;
                if (line_valid && line_dirty) begin
                    next_state = FLUSH_WAIT;
                end else begin
                    store.wen = 3'b110;  // clean line, just invalidate
                    scan_step = 1'b1;
                    if (last_set) begin
                        flush_done = 1'b1;
                        next_state = LOOKUP;
                    end
                end
            end
            FLUSH_WAIT: begin
                xfer.req = !xfer.ack;
                xfer.op  = EVICT;
                xfer.set = scan_cnt;
                if (xfer.ack) begin
                    scan_step  = 1'b1;
                    flush_done = last_set;
                    next_state = last_set ? LOOKUP : FLUSH_SCAN;
                end
            end
            default: next_state = CLEAR;
        endcase
    end

endmodule

// File: design/l1_dcache.sv
// direct-mapped write-back L1 data cache top: controller, transfer engine and line array
`timescale 1ns/1ps

module l1_dcache import cache_pkg::*; #(
    parameter int CACHE_SIZE = 1024,  // bytes, power of two
    parameter int BLOCK_SIZE = 4      // words, power of two up to 8
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     flush,
    output logic     flush_done,
    // processor side
    input  logic     proc_ren,
    input  logic     proc_wen,
    input  word_t    proc_addr,
    input  byte_en_t proc_byte_en,
    input  word_t    proc_wdata,
    output word_t    proc_rdata,
    output logic     proc_busy,
    // memory side
    output logic     mem_ren,
    output logic     mem_wen,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    input  word_t    mem_rdata,
    input  logic     mem_busy
);

    store_port_if #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE)) ctrl_port ();
    store_port_if #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE)) xfer_port ();
    xfer_if       #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE)) xfer_link ();

    cache_ctrl #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE)) u_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .flush_done   (flush_done),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_addr    (proc_addr),
        .proc_byte_en (proc_byte_en),
        .proc_wdata   (proc_wdata),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .store        (ctrl_port.master),
        .xfer         (xfer_link.initiator)
    );

    line_transfer #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE)) u_xfer (
        .CLK       (CLK),
        .nRST      (nRST),
        .cmd       (xfer_link.target),
        .store     (xfer_port.master),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_busy  (mem_busy)
    );

    cache_store #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE)) u_store (
        .CLK    (CLK),
        .nRST   (nRST),
        .port_a (ctrl_port.array),
        .port_b (xfer_port.array)
    );

endmodule

// File: verification/mem_model.sv
// testbench memory with LFSR-timed busy and a log of accepted writes
`timescale 1ns/1ps

module mem_model #(
    parameter int          WORDS = 1024,
    parameter logic [15:0] SEED  = 16'd16274
) (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        mem_ren,
    input  logic        mem_wen,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    output logic [31:0] mem_rdata,
    output logic        mem_busy
);

    localparam int AW = $clog2(WORDS);

    logic [31:0] mem [WORDS];
    logic [31:0] wr_addr_log [$];  // accepted writes, oldest first
    logic [31:0] wr_data_log [$];
    logic [15:0] lfsr, step1, step2;
    logic [1:0]  wait_cnt;         // cycles left before the held word is taken

    // Fibonacci taps at 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // odd multiplier keeps every byte address distinct
    initial begin
        for (int i = 0; i < WORDS; i++)
            mem[i] = ((32'(i) << 2) * 32'h9E37_79B1) ^ 32'h5A3C_0F96;
    end

    assign step1     = lfsr_step(lfsr);  // one step per delay bit
    assign step2     = lfsr_step(step1);
    assign mem_rdata = mem[mem_addr[AW+1:2]];
    assign mem_busy  = !(mem_ren || mem_wen) || (wait_cnt != 2'd0);

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lfsr     <= SEED;
            wait_cnt <= 2'd0;
        end else if ((mem_ren || mem_wen) && !mem_busy) begin
            if (mem_wen) begin
                mem[mem_addr[AW+1:2]] <= mem_wdata;
                wr_addr_log.push_back(mem_addr);
                wr_data_log.push_back(mem_wdata);
            end
            lfsr     <= step2;
            wait_cnt <= {step1[0], step2[0]};  // 0 to 3 cycles for the next word
        end else if (mem_ren || mem_wen) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

endmodule

// File: verification/tb_l1_dcache.sv
// L1 data cache testbench with shadow memory, traffic monitor and assertion checks
`timescale 1ns/1ps

module tb_l1_dcache import cache_pkg::*; ();

    logic     CLK, nRST, flush, flush_done;
    logic     proc_ren, proc_wen, proc_busy;
    word_t    proc_addr, proc_wdata, proc_rdata;
    byte_en_t proc_byte_en;
    logic     mem_ren, mem_wen, mem_busy;
    word_t    mem_addr, mem_wdata, mem_rdata;

    word_t        shadow [1024];  // expected contents, per word
    logic [255:0] dirty_blk;      // blocks the cache holds dirty
    logic         quiet;          // hits only, memory must stay idle
    int           errors, accesses, rd_words, wr_words, done_pulses;
    event         give_up;

    l1_dcache #(.CACHE_SIZE(256), .BLOCK_SIZE(4)) UUT (.*);
    mem_model #(.WORDS(1024), .SEED(16'd16274)) u_mem (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        if (mem_ren && !mem_busy)
            rd_words <= rd_words + 1;
        if (mem_wen && !mem_busy) begin
            wr_words <= wr_words + 1;
            if (mem_addr[3:2] == 2'd3)
                dirty_blk[mem_addr[11:4]] <= 1'b0;  // whole block back in memory
        end
        if (flush_done)
            done_pulses <= done_pulses + 1;
    end

    task automatic log_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic print_summary();
        $display("errors %0d, accesses %0d, memory reads %0d, memory writes %0d, flush pulses %0d",
                 errors, accesses, rd_words, wr_words, done_pulses);
    endtask

    assert property (@(posedge CLK) disable iff (!nRST)
        (proc_ren && !proc_busy) |-> proc_rdata == shadow[proc_addr[11:2]])
        else log_mismatch("read data differs from shadow memory");
    assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren && !mem_busy) |-> mem_addr == {proc_addr[31:4], rd_words[1:0], 2'b00})
        else log_mismatch("fill read out of order or outside the missed block");
    assert property (@(posedge CLK) disable iff (!nRST)
        (mem_wen && !mem_busy) |-> (mem_wdata == shadow[mem_addr[11:2]]
            && mem_addr[3:2] == wr_words[1:0] && dirty_blk[mem_addr[11:4]]))
        else log_mismatch("write-back word does not match a dirty block");
    assert property (@(posedge CLK) disable iff (!nRST) !(quiet && (mem_ren || mem_wen)))
        else log_mismatch("memory traffic during a hit");
    assert property (@(posedge CLK) disable iff (!nRST) flush_done |-> dirty_blk == '0)
        else log_mismatch("flush finished with dirty blocks left");

    // hold one access until the cache takes it, then count the memory words it moved
    task automatic cpu_access(input logic is_write, input word_t addr, input word_t data,
                              input byte_en_t be, input int n_rd, input int n_wr);
        int cycles;
        int rd0;
        int wr0;
        rd0          = rd_words;
        wr0          = wr_words;
        proc_ren     = !is_write;
        proc_wen     = is_write;
        proc_addr    = addr;
        proc_wdata   = data;
        proc_byte_en = be;
        cycles       = 0;
        @(negedge CLK);
        while (proc_busy && cycles < 200) begin
            cycles++;
            @(negedge CLK);
        end
        if (proc_busy) begin
            $display("timeout: cache stayed busy on the access to %h", addr);
            -> give_up;
        end
        @(posedge CLK);  // access completes here
        #1;
        if (is_write) begin
            for (int b = 0; b < 4; b++)
                if (be[b])
                    shadow[addr[11:2]][b*8 +: 8] = data[b*8 +: 8];
            dirty_blk[addr[11:4]] = 1'b1;
        end
        proc_ren = 1'b0;
        proc_wen = 1'b0;
        accesses++;
        assert (rd_words - rd0 == n_rd && wr_words - wr0 == n_wr)
            else log_mismatch($sformatf("access to %h moved %0d reads and %0d writes",
                                        addr, rd_words - rd0, wr_words - wr0));
    endtask

    task automatic flush_cache();
        int cycles;
        int pulses0;
        pulses0 = done_pulses;
        flush   = 1'b1;
        @(posedge CLK);
        #1;
        flush  = 1'b0;
        cycles = 0;
        @(negedge CLK);
        while (!flush_done && cycles < 500) begin
            cycles++;
            @(negedge CLK);
        end
        if (!flush_done) begin
            $display("timeout: no flush_done after a flush request");
            -> give_up;
        end
        repeat (4) @(posedge CLK);  // room for a stray second pulse
        #1;
        assert (done_pulses == pulses0 + 1)
            else log_mismatch($sformatf("%0d done pulses for one flush", done_pulses - pulses0));
    endtask

    initial begin
        int mismatches;
        int n;
        nRST         = 1'b0;
        flush        = 1'b0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        quiet        = 1'b0;
        dirty_blk    = '0;
        errors       = 0;
        accesses     = 0;
        rd_words     = 0;
        wr_words     = 0;
        done_pulses  = 0;
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;
        for (int i = 0; i < 1024; i++)
            shadow[i] = u_mem.mem[i];

        cpu_access(1'b0, 32'h040, '0, '0, 4, 0);  // cold misses
        cpu_access(1'b0, 32'h154, '0, '0, 4, 0);
        cpu_access(1'b0, 32'h2A8, '0, '0, 4, 0);
        cpu_access(1'b0, 32'h3FC, '0, '0, 4, 0);

        quiet = 1'b1;
        for (int m = 1; m < 16; m += 3) begin
            cpu_access(1'b1, 32'h044, 32'hC0DE_0000 + m, byte_en_t'(m), 0, 0);
            cpu_access(1'b0, 32'h044, '0, '0, 0, 0);
        end
        quiet = 1'b0;

        // same set as the dirty 0x040 block, other tag
        cpu_access(1'b0, 32'h144, '0, '0, 4, 4);
        n = u_mem.wr_addr_log.size();
        for (int k = 0; k < 4; k++)
            assert (u_mem.wr_addr_log[n-4+k] == 32'h040 + 4 * k
                    && u_mem.wr_data_log[n-4+k] == shadow[16+k])
                else log_mismatch("write-back missed the old block");

        cpu_access(1'b0, 32'h254, '0, '0, 4, 0);  // clean victim just dropped

        cpu_access(1'b1, 32'h2A8, 32'h1111_2222, 4'b1111, 0, 0);
        cpu_access(1'b1, 32'h3F0, 32'h3333_4444, 4'b0011, 0, 0);
        cpu_access(1'b1, 32'h148, 32'h5555_6666, 4'b1100, 0, 0);
        cpu_access(1'b1, 32'h5C0, 32'h7777_8888, 4'b1001, 4, 0);  // write miss, clean set
        flush_cache();
        mismatches = 0;
        for (int i = 0; i < 1024; i++)
            if (u_mem.mem[i] !== shadow[i])
                mismatches++;
        assert (mismatches == 0)
            else log_mismatch($sformatf("%0d memory words differ after flush", mismatches));

        cpu_access(1'b0, 32'h2A8, '0, '0, 4, 0);  // invalidated, refill
        cpu_access(1'b0, 32'h14C, '0, '0, 4, 0);
        cpu_access(1'b0, 32'h040, '0, '0, 4, 0);

        print_summary();
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial begin
        @(give_up);
        errors++;
        print_summary();
        $display("Test failed");
        $finish;
    end

endmodule

// File: build.f
design/cache_pkg.sv
design/store_port_if.sv
design/xfer_if.sv
design/cache_store.sv
design/line_transfer.sv
design/cache_ctrl.sv
design/l1_dcache.sv
verification/mem_model.sv
verification/tb_l1_dcache.sv

// File: Bender.yml
package:
  name: l1_dcache

sources:
  - files:
      - design/cache_pkg.sv
      - design/store_port_if.sv
      - design/xfer_if.sv
      - design/cache_store.sv
      - design/line_transfer.sv
      - design/cache_ctrl.sv
      - design/l1_dcache.sv
  - target: test
    files:
      - verification/mem_model.sv
      - verification/tb_l1_dcache.sv
